/* rtl/i2c_bridge_pkg.sv */
// I2C port bridge shared definitions
// Byte and port sizes, FSM states, received byte views and the
// strobe bundles passed between the bridge blocks

package i2c_bridge_pkg;

	// ******************************************************************
	// Sizes
	// ******************************************************************
	localparam int byte_w     = 8;   // Serial byte width
	localparam int port_count = 16;  // Host ports behind the bridge
	localparam int ack_slot   = 9;   // Bit count of the acknowledge clock

	// Read data of every port, port 0 in the low byte
	typedef logic [port_count-1:0][byte_w-1:0] port_data_t;

	// Transfer states
	typedef enum logic [2:0]
	{
		idle  = 3'd0,  // Bus free or transfer not for us
		addr  = 3'd1,  // Device address byte
		loc   = 3'd2,  // Location byte, writes only
		data  = 3'd3,  // Data byte in or out
		check = 3'd4,  // Checksum byte in or out
		done  = 3'd5   // Transfer over, wait for stop or start
	} i2c_state_e;

	// First byte after a start
	typedef struct packed
	{
		logic [6:0] dev_addr;  // Slave address
		logic       rd_wr;     // 1 = read
	} addr_byte_t;

	// Location byte, port in the high nibble
	typedef struct packed
	{
		logic [3:0] port;
		logic [3:0] offset;
	} loc_byte_t;

	// Received byte read as address or as location
	typedef union packed
	{
		logic [byte_w-1:0] raw;
		addr_byte_t        as_addr;
		loc_byte_t         as_loc;
	} i2c_byte_u;

	// Line events, one SYSCLK each except sda_level
	typedef struct packed
	{
		logic start;
		logic stop;
		logic scl_rise;
		logic scl_fall;
		logic sda_level;  // Synchronized SDA, aligned with the edges
	} bus_events_t;

	// FSM strobes towards the register block
	typedef struct packed
	{
		logic loc_done;    // Location byte in
		logic data_done;   // Write data byte in
		logic check_done;  // Write checksum acknowledged
		logic rd_load;     // Fetch port byte for a read
		logic rd_check;    // Send the read checksum next
	} byte_phase_t;

endpackage

/* rtl/i2c_line_sampler.sv */
// I2C line sampler
// Brings SCL and SDA into the SYSCLK domain and turns them into
// SCL edge, start and stop strobes

module i2c_line_sampler
(
	input  logic                        sysclk,
	input  logic                        reset_n,
	input  logic                        scl,
	input  logic                        sda,
	output i2c_bridge_pkg::bus_events_t events
);

	logic [1:0] scl_sync;  // Two stage synchronizer, [1] is settled
	logic [1:0] sda_sync;
	logic       scl_q;     // Settled SCL one cycle older
	logic       sda_q;     // Settled SDA one cycle older

	// ******************************************************************
	// Synchronizers
	// ******************************************************************
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			scl_sync <= 2'b11;  // Bus idles high, no false edge out of reset
			sda_sync <= 2'b11;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[0], scl};
			sda_sync <= {sda_sync[0], sda};
			scl_q    <= scl_sync[1];
			sda_q    <= sda_sync[1];
		end
	end

	// ******************************************************************
	// Edge and condition strobes
	// ******************************************************************
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
			events <= '0;
		else
		begin
			// SDA falling with SCL held high
			events.start     <= scl_sync[1] & scl_q & sda_q & ~sda_sync[1];
			// SDA rising with SCL held high
			events.stop      <= scl_sync[1] & scl_q & ~sda_q & sda_sync[1];
			events.scl_rise  <= scl_sync[1] & ~scl_q;
			events.scl_fall  <= ~scl_sync[1] & scl_q;
			events.sda_level <= sda_sync[1];  // Same stage as the edges
		end
	end

endmodule

/* rtl/i2c_frame_fsm.sv */
// I2C transfer FSM
// Counts bits per byte, matches the device address, walks the
// write and read byte sequence and raises the per-byte strobes

module i2c_frame_fsm
(
	input  logic                        sysclk,
	input  logic                        reset_n,
	input  i2c_bridge_pkg::bus_events_t events,
	input  i2c_bridge_pkg::i2c_byte_u   rx_byte,
	input  logic [6:0]                  dev_addr,
	output i2c_bridge_pkg::byte_phase_t phase,
	output i2c_bridge_pkg::i2c_state_e  state,
	output logic                        rd_wr,
	output logic                        ack_drive
);
	import i2c_bridge_pkg::*;

	logic [3:0] bit_cnt;     // SCL rises since byte start
	logic       addr_hit;    // Address byte matched the straps
	logic       addr_match;  // Live compare of the received byte
	logic       bits_done;   // SCL fall after the eighth bit
	logic       ack_rise;    // SCL rise of the acknowledge bit
	logic       byte_end;    // SCL fall of the acknowledge bit

	assign addr_match = (rx_byte.as_addr.dev_addr == dev_addr);
	assign bits_done  = events.scl_fall && (bit_cnt == 4'(byte_w));
	assign ack_rise   = events.scl_rise && (bit_cnt == 4'(byte_w));
	assign byte_end   = events.scl_fall && (bit_cnt == 4'(ack_slot));

	// Bit counter, 0 up to the acknowledge slot
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
			bit_cnt <= '0;
		else if (events.start || events.stop || byte_end || state == idle)
			bit_cnt <= '0;
		else if (events.scl_rise && bit_cnt != 4'(ack_slot))
			bit_cnt <= bit_cnt + 1'b1;
	end

	// Address compare and direction
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			addr_hit <= 1'b0;
			rd_wr    <= 1'b0;
		end
		else if (events.start || events.stop)
		begin
			addr_hit <= 1'b0;
			rd_wr    <= 1'b0;
		end
		else if (bits_done && state == addr)
		begin
			addr_hit <= addr_match;
			rd_wr    <= addr_match & rx_byte.as_addr.rd_wr;  // Only a hit may read
		end
	end

	// ******************************************************************
	// Byte sequence
	// ******************************************************************
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state     <= idle;
			ack_drive <= 1'b0;
			phase     <= '0;
		end
		else
		begin
			phase <= '0;  // All strobes last one cycle
			if (events.start)
			begin
				state     <= addr;  // Also a repeated start
				ack_drive <= 1'b0;
			end
			else if (events.stop)
			begin
				state     <= idle;
				ack_drive <= 1'b0;
			end
			else
			begin
				// Read side: fetch the port, then watch the master's ACK
				if (ack_rise && rd_wr)
				begin
					if (state == addr && addr_hit)
						phase.rd_load <= 1'b1;
					else if (state == data)
					begin
						if (!events.sda_level)
							phase.rd_check <= 1'b1;  // ACK, checksum follows
						else
							state <= idle;           // NACK ends the read
					end
				end
				// Eight bits in, decide on our acknowledge
				if (bits_done)
				begin
					case (state)
						addr:  ack_drive <= addr_match;
						loc:
						begin
							ack_drive      <= 1'b1;
							phase.loc_done <= 1'b1;
						end
						data:
						begin
							ack_drive       <= ~rd_wr;
							phase.data_done <= ~rd_wr;
						end
						check: ack_drive <= ~rd_wr;
						default: ack_drive <= 1'b0;
					endcase
				end
				// Acknowledge clock gone, next byte
				if (byte_end)
				begin
					ack_drive <= 1'b0;
					case (state)
						addr:  state <= addr_hit ? (rd_wr ? data : loc) : idle;
						loc:   state <= data;
						data:  state <= check;
						check:
						begin
							state            <= done;
							phase.check_done <= ~rd_wr;  // Commit point of a write
						end
						default: state <= state;
					endcase
				end
			end
		end
	end

endmodule

/* rtl/i2c_byte_shifter.sv */
// I2C byte shifter
// Collects SDA bits into the received byte and sends read bytes
// MSB first; drives the open-drain pull-low enable of SDA

module i2c_byte_shifter
(
	input  logic                                sysclk,
	input  logic                                reset_n,
	input  i2c_bridge_pkg::bus_events_t         events,
	input  i2c_bridge_pkg::i2c_state_e          state,
	input  logic                                rd_wr,
	input  logic                                ack_drive,
	input  logic                                load,
	input  logic [i2c_bridge_pkg::byte_w-1:0]   tx_byte,
	output i2c_bridge_pkg::i2c_byte_u           rx_byte,
	output logic                                sda_oe
);
	import i2c_bridge_pkg::*;

	logic [byte_w:0] tx_shift;  // Byte plus a trailing marker bit
	logic            tx_armed;  // Bits left to send
	logic            tx_low;    // Current bit is a zero
	logic            tx_flush;

	// Abandon a byte in flight on any bus condition
	assign tx_flush = events.start || events.stop || (state == idle);

	// Receive side
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
			rx_byte <= '0;
		else if (state == idle)
			rx_byte <= '0;
		else if (events.scl_rise && !ack_drive)  // Skip our own ACK bit
			rx_byte.raw <= {rx_byte.raw[byte_w-2:0], events.sda_level};
	end

	// ******************************************************************
	// Transmit side
	// ******************************************************************
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			tx_shift <= '0;
			tx_armed <= 1'b0;
			tx_low   <= 1'b0;
		end
		else if (tx_flush)
		begin
			tx_shift <= '0;
			tx_armed <= 1'b0;
			tx_low   <= 1'b0;
		end
		else if (load)
		begin
			tx_shift <= {tx_byte, 1'b1};  // Marker shifts out as a release
			tx_armed <= rd_wr;
		end
		else if (events.scl_fall && tx_armed)
		begin
			tx_low   <= ~tx_shift[byte_w];  // New bit while SCL is low
			tx_shift <= tx_shift << 1;
			tx_armed <= |tx_shift[byte_w-1:0];  // Stop after the marker
		end
	end

	// Pull-low enable, ACK slot or a zero data bit
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
			sda_oe <= 1'b0;
		else
			sda_oe <= ack_drive | tx_low;
	end

endmodule

/* rtl/port_access_regs.sv */
// Port access registers
// Holds location, write data and read byte; decodes port and
// offset selects, checks the write checksum and builds the
// byte and checksum sent back on a read

module port_access_regs
(
	input  logic                                    sysclk,
	input  logic                                    reset_n,
	input  i2c_bridge_pkg::byte_phase_t             phase,
	input  logic                                    rd_wr,
	input  i2c_bridge_pkg::i2c_byte_u               rx_byte,
	input  i2c_bridge_pkg::port_data_t              port_din,
	output logic [i2c_bridge_pkg::byte_w-1:0]       tx_byte,
	output logic [i2c_bridge_pkg::byte_w-1:0]       data_out,
	output logic [i2c_bridge_pkg::port_count-1:0]   port_cs,
	output logic [i2c_bridge_pkg::port_count-1:0]   offset_sel
);
	import i2c_bridge_pkg::*;

	loc_byte_t             loc_q;      // Current location
	logic [byte_w-1:0]     data_q;     // Last write data byte
	logic [byte_w-1:0]     rd_q;       // Byte fetched for a read
	logic [byte_w-1:0]     sum;        // Data plus received checksum
	logic                  sum_ok;
	logic                  wr_commit;
	logic [port_count-1:0] port_dec;   // One-hot port of the location

	// ******************************************************************
	// Location and write data
	// ******************************************************************
	always_ff @(posedge sysclk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			loc_q  <= '0;
			data_q <= '0;
		end
		else
		begin
			if (phase.loc_done)
				loc_q <= rx_byte.as_loc;
			else if (phase.rd_check)
				loc_q <= loc_byte_t'(loc_q + 1'b1);  // Auto increment on read
			if (phase.data_done)
				data_q <= rx_byte.raw;
		end
	end

	// Read byte, taken with the read port select
	always_ff @(posedge sysclk)
	begin
		if (phase.rd_load)
			rd_q <= port_din[loc_q.port];
	end

	// ******************************************************************
	// Decode and checksum
	// ******************************************************************
	assign port_dec   = port_count'(1) << loc_q.port;
	assign offset_sel = port_count'(1) << loc_q.offset;

	// Receiver still holds the checksum byte at check_done
	assign sum       = data_q + rx_byte.raw;
	assign sum_ok    = (sum == '0);
	assign wr_commit = phase.check_done & ~rd_wr & sum_ok;

	// One-cycle select, write commit or read fetch
	assign port_cs = (wr_commit || phase.rd_load) ? port_dec : '0;

	// Port byte first, then its two's complement
	assign tx_byte = phase.rd_check ? (~rd_q + 1'b1) : port_din[loc_q.port];

	assign data_out = data_q;

endmodule

/* rtl/i2c_port_bridge.sv */
// I2C to port bridge, top level
// Slave on a two-wire bus giving checksum-protected byte access
// to sixteen host ports; SDA is open drain

module i2c_port_bridge
(
	input  logic                                    sysclk,
	input  logic                                    reset_n,
	input  logic                                    scl,
	input  logic                                    sda_in,
	output logic                                    sda_oe,      // 1 pulls SDA low
	input  logic [6:0]                              dev_addr,    // Strap pins
	input  i2c_bridge_pkg::port_data_t              port_din,
	output logic [i2c_bridge_pkg::byte_w-1:0]       data_out,
	output logic [i2c_bridge_pkg::port_count-1:0]   port_cs,
	output logic [i2c_bridge_pkg::port_count-1:0]   offset_sel,
	output logic                                    rd_wr
);
	import i2c_bridge_pkg::*;

	bus_events_t       events;
	byte_phase_t       phase;
	i2c_state_e        state;
	i2c_byte_u         rx_byte;
	logic              ack_drive;
	logic              shift_load;  // Port byte or checksum into the shifter
	logic [byte_w-1:0] tx_byte;

	assign shift_load = phase.rd_load | phase.rd_check;

	i2c_line_sampler i2c_line_sampler_inst
	(
		.sysclk  (sysclk),
		.reset_n (reset_n),
		.scl     (scl),
		.sda     (sda_in),
		.events  (events)
	);

	i2c_frame_fsm i2c_frame_fsm_inst
	(
		.sysclk    (sysclk),
		.reset_n   (reset_n),
		.events    (events),
		.rx_byte   (rx_byte),
		.dev_addr  (dev_addr),
		.phase     (phase),
		.state     (state),
		.rd_wr     (rd_wr),
		.ack_drive (ack_drive)
	);

	i2c_byte_shifter i2c_byte_shifter_inst
	(
		.sysclk    (sysclk),
		.reset_n   (reset_n),
		.events    (events),
		.state     (state),
		.rd_wr     (rd_wr),
		.ack_drive (ack_drive),
		.load      (shift_load),
		.tx_byte   (tx_byte),
		.rx_byte   (rx_byte),
		.sda_oe    (sda_oe)
	);

	port_access_regs port_access_regs_inst
	(
		.sysclk     (sysclk),
		.reset_n    (reset_n),
		.phase      (phase),
		.rd_wr      (rd_wr),
		.rx_byte    (rx_byte),
		.port_din   (port_din),
		.tx_byte    (tx_byte),
		.data_out   (data_out),
		.port_cs    (port_cs),
		.offset_sel (offset_sel)
	);

endmodule

/* testbench/i2c_master_tasks.svh */
// I2C bus master tasks
// Start, stop, byte write and byte read on the open-drain bus of
// the testbench; one SCL period is four quarters of SYSCLK cycles

`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

	// Wait on SYSCLK rising edges
	task automatic idle_cycles(input int count);
		repeat (count) @(posedge sysclk);
	endtask

	// One SCL clock, SCL low on entry and on exit
	task automatic clock_bit(input logic bit_out, output logic bit_in);
		idle_cycles(quarter);
		sda_drv <= bit_out;       // SDA moves only while SCL is low
		idle_cycles(quarter);
		scl_drv <= 1'b1;
		idle_cycles(quarter);
		@(negedge sysclk);
		bit_in = sda;             // Middle of the high phase
		idle_cycles(quarter);
		scl_drv <= 1'b0;
	endtask

	// Start or repeated start, leaves SCL low
	task automatic start_condition();
		idle_cycles(quarter);
		sda_drv <= 1'b1;
		idle_cycles(quarter);
		scl_drv <= 1'b1;
		idle_cycles(2 * quarter);
		sda_drv <= 1'b0;          // SDA falls with SCL high
		idle_cycles(2 * quarter);
		scl_drv <= 1'b0;
	endtask

	// Stop from SCL low, bus left idle
	task automatic stop_condition();
		idle_cycles(quarter);
		sda_drv <= 1'b0;
		idle_cycles(quarter);
		scl_drv <= 1'b1;
		idle_cycles(2 * quarter);
		sda_drv <= 1'b1;          // SDA rises with SCL high
		idle_cycles(2 * quarter);
	endtask

	// MSB first, then the slave's acknowledge (1 = ACK)
	task automatic write_byte(input logic [7:0] value, output logic ack);
		logic sampled;
		for (int i = 7; i >= 0; i--)
			clock_bit(value[i], sampled);
		clock_bit(1'b1, sampled);  // Released for the slave
		ack = ~sampled;
	endtask

	// Slave byte in, then our ACK or NACK
	task automatic read_byte(input logic send_ack, output logic [7:0] value);
		logic sampled;
		for (int i = 7; i >= 0; i--)
		begin
			clock_bit(1'b1, sampled);
			value[i] = sampled;
		end
		clock_bit(~send_ack, sampled);  // Low for ACK
	endtask

`endif

/* testbench/tb_i2c_port_bridge.sv */
// I2C port bridge testbench
// Bus master, host port model and directed tests for write commit,
// checksum reject, reads with auto increment and aborted writes

module tb_i2c_port_bridge;
	timeunit 1ns;
	timeprecision 1ps;
	import i2c_bridge_pkg::*;

	// ******************************************************************
	// Timing and fixed values
	// ******************************************************************
	localparam int clk_period   = 8;
	localparam int reset_cycles = 8;
	localparam int quarter      = 6;   // SYSCLK per quarter of an SCL period
	localparam int bit_cycles   = 4 * quarter;
	// Bit times of tests 1 to 6, start and stop at 1.5 bits each
	localparam int test_bits    = 39 + 39 + 39 + 51 + 30 + 101;
	localparam int margin       = 2000;  // Cycles for gaps and settling
	localparam int watchdog_ns  =
		(reset_cycles + test_bits * bit_cycles + margin) * clk_period;
	localparam logic [6:0] own_addr = 7'h2C;  // Strap pins

	logic        sysclk;
	logic        reset_n;
	logic        scl_drv;              // Master SCL
	logic        sda_drv;              // Master SDA, 0 pulls low
	logic        sda;                  // Resolved open-drain line
	logic        sda_oe;
	logic [6:0]  dev_addr;
	port_data_t  port_din;
	logic [7:0]  data_out;
	logic [15:0] port_cs;
	logic [15:0] offset_sel;
	logic        rd_wr;
	int          error_count = 0;
	int          tests_run   = 0;
	int          cs_total    = 0;      // port_cs pulses seen so far
	logic [15:0] cs_seen     = '0;     // Last non-zero port_cs

	assign sda = sda_drv & ~sda_oe;    // Wired AND with the slave

	`include "i2c_master_tasks.svh"

	i2c_port_bridge i2c_port_bridge_inst
	(
		.sysclk     (sysclk),
		.reset_n    (reset_n),
		.scl        (scl_drv),
		.sda_in     (sda),
		.sda_oe     (sda_oe),
		.dev_addr   (dev_addr),
		.port_din   (port_din),
		.data_out   (data_out),
		.port_cs    (port_cs),
		.offset_sel (offset_sel),
		.rd_wr      (rd_wr)
	);

	initial
	begin
		sysclk = 1'b0;
		forever #(clk_period / 2) sysclk = ~sysclk;
	end

	// Host port side, every select cycle counted
	always @(negedge sysclk)
	begin
		if (port_cs != '0)
		begin
			cs_total <= cs_total + 1;
			cs_seen  <= port_cs;
		end
	end

	// ******************************************************************
	// Check helpers and transfers
	// ******************************************************************
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
		error_count++;
	endtask

	task automatic send_checked(input logic [7:0] value, input logic exp_ack);
		logic ack;
		write_byte(value, ack);
		if (ack !== exp_ack)
			report_mismatch("sda ack", ack, exp_ack);
	endtask

	task automatic set_location(input logic [7:0] loc);
		start_condition();
		send_checked({own_addr, 1'b0}, 1'b1);
		send_checked(loc, 1'b1);
		stop_condition();         // No data, nothing to commit
	endtask

	task automatic write_transfer(input logic [7:0] loc, input logic [7:0] value,
		input logic [7:0] chk);
		start_condition();
		send_checked({own_addr, 1'b0}, 1'b1);
		send_checked(loc, 1'b1);
		send_checked(value, 1'b1);
		send_checked(chk, 1'b1);  // Acked even when the sum is wrong
		stop_condition();
	endtask

	task automatic read_transfer(output logic [7:0] value, output logic [7:0] chk);
		start_condition();
		send_checked({own_addr, 1'b1}, 1'b1);
		@(negedge sysclk);
		if (rd_wr !== 1'b1)
			report_mismatch("rd_wr", rd_wr, 1);
		read_byte(1'b1, value);
		read_byte(1'b0, chk);     // NACK the checksum, then stop
		stop_condition();
	endtask

	// Write with a good or a broken checksum
	task automatic write_and_check(input logic [7:0] loc, input logic [7:0] value,
		input logic chk_ok);
		logic [7:0]  chk;
		logic [15:0] port_bit;
		int          pulses;
		chk = 8'h00 - value;      // Data plus checksum is zero
		if (!chk_ok)
			chk = chk ^ 8'h80;
		port_bit = 16'h0001 << loc[7:4];
		pulses   = cs_total;
		write_transfer(loc, value, chk);
		@(negedge sysclk);
		if (cs_total != pulses + (chk_ok ? 1 : 0))
			report_mismatch("port_cs pulses", cs_total - pulses, chk_ok);
		if (chk_ok && cs_seen !== port_bit)
			report_mismatch("port_cs", cs_seen, port_bit);
		if (data_out !== value)
			report_mismatch("data_out", data_out, value);
		if (offset_sel !== 16'h0001 << loc[3:0])
			report_mismatch("offset_sel", offset_sel, 16'h0001 << loc[3:0]);
	endtask

	// Read from the current location
	task automatic read_and_check(input logic [7:0] loc);
		logic [7:0] value;
		logic [7:0] chk;
		logic [7:0] exp_value;
		logic [7:0] exp_chk;
		int         pulses;
		exp_value = port_din[loc[7:4]];
		exp_chk   = 8'h00 - exp_value;  // Two's complement
		pulses    = cs_total;
		read_transfer(value, chk);
		@(negedge sysclk);
		if (value !== exp_value)
			report_mismatch("read data", value, exp_value);
		if (chk !== exp_chk)
			report_mismatch("read checksum", chk, exp_chk);
		if (cs_total != pulses + 1)
			report_mismatch("port_cs pulses", cs_total - pulses, 1);
		if (cs_seen !== 16'h0001 << loc[7:4])
			report_mismatch("port_cs", cs_seen, 16'h0001 << loc[7:4]);
	endtask

	// ******************************************************************
	// Directed tests
	// ******************************************************************
	task automatic test_reset_and_foreign_addr();
		int pulses;
		tests_run++;
		@(negedge sysclk);
		if (sda_oe !== 1'b0)
			report_mismatch("sda_oe", sda_oe, 0);
		if (port_cs !== '0)
			report_mismatch("port_cs", port_cs, 0);
		if (rd_wr !== 1'b0)
			report_mismatch("rd_wr", rd_wr, 0);
		pulses = cs_total;
		start_condition();
		send_checked({own_addr ^ 7'h01, 1'b0}, 1'b0);  // Not our address
		send_checked(8'h10, 1'b0);
		send_checked(8'h55, 1'b0);
		send_checked(8'hAB, 1'b0);
		stop_condition();
		@(negedge sysclk);
		if (cs_total != pulses)
			report_mismatch("port_cs pulses", cs_total - pulses, 0);
	endtask

	task automatic test_aborted_writes();
		int pulses;
		tests_run++;
		pulses = cs_total;
		start_condition();
		send_checked({own_addr, 1'b0}, 1'b1);
		send_checked(8'h72, 1'b1);
		send_checked(8'h11, 1'b1);
		start_condition();        // Repeated start before the checksum
		send_checked(8'hDE, 1'b0);  // Address byte after the restart, not ours
		stop_condition();
		set_location(8'h85);
		@(negedge sysclk);
		if (cs_total != pulses)
			report_mismatch("port_cs pulses", cs_total - pulses, 0);
		write_and_check(8'h85, 8'h6E, 1'b1);
	endtask

	initial
	begin
		void'($urandom(55811));  // Seed once
		reset_n  <= 1'b0;
		scl_drv  <= 1'b1;
		sda_drv  <= 1'b1;
		dev_addr <= own_addr;
		for (int i = 0; i < port_count; i++)
			port_din[i] <= 8'($urandom);
		repeat (reset_cycles) @(posedge sysclk);
		reset_n <= 1'b1;
		idle_cycles(4);
		test_reset_and_foreign_addr();
		tests_run++;
		write_and_check(8'h5A, 8'h3C, 1'b1);
		tests_run++;
		write_and_check(8'h27, 8'hA5, 1'b0);
		tests_run++;
		set_location(8'h3F);      // Offset 15, the increment carries into the port
		read_and_check(8'h3F);
		tests_run++;
		read_and_check(8'h3F + 8'h01);
		test_aborted_writes();
		idle_cycles(10);
		$display("Tests run: %0d, errors: %0d", tests_run, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* build.f */
+incdir+testbench
rtl/i2c_bridge_pkg.sv
rtl/i2c_line_sampler.sv
rtl/i2c_frame_fsm.sv
rtl/i2c_byte_shifter.sv
rtl/port_access_regs.sv
rtl/i2c_port_bridge.sv
testbench/tb_i2c_port_bridge.sv

/* Makefile */
# Verilator build and run of the I2C port bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_port_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
